/* verilog/mul_pkg.sv */
// shared widths and sizing helpers for the pipelined wide multiplier
// modules pull the defaults into their headers and size their
// digit arrays, adder tree and latency with the functions below
package mul_pkg;

        // default operand width, product is twice this
        localparam int DEF_OPERAND_W = 256;

        // digit widths of the two operands
        // x digits are 24 bits, so the top one is padded
        localparam int DEF_X_DIGIT_W = 24;
        localparam int DEF_Y_DIGIT_W = 16;

        // digits needed to cover the operand, rounded up
        function automatic int digit_count(input int operand_w, input int digit_w);
                return (operand_w + digit_w - 1) / digit_w;
        endfunction

        // one partial product per x digit and y digit pair
        function automatic int term_count(input int operand_w,
                                          input int x_digit_w,
                                          input int y_digit_w);
                return digit_count(operand_w, x_digit_w) * digit_count(operand_w, y_digit_w);
        endfunction

        // pairwise levels to bring the terms down to one
        // ceil(log2), with an odd leftover passed to the next level
        function automatic int tree_depth(input int terms);
                int depth;
                int remaining;
                depth     = 0;
                remaining = terms;
                while (remaining > 1) begin
                        remaining = (remaining + 1) / 2;
                        depth     = depth + 1;
                end
                return depth;
        endfunction

        // cycles from the sampling edge of in_valid to out_valid
        // one for the digit products, then one per tree level
        function automatic int mul_latency(input int operand_w,
                                           input int x_digit_w,
                                           input int y_digit_w);
                return 1 + tree_depth(term_count(operand_w, x_digit_w, y_digit_w));
        endfunction

endpackage

/* verilog/partial_product_array.sv */
// first pipeline stage of the wide multiplier
// splits x and y into digits, multiplies every x digit by every y digit
// and registers each product already shifted to its bit weight
// terms holds one double-width field per product, ordered x-major
module partial_product_array #(
        parameter  int OPERAND_W = mul_pkg::DEF_OPERAND_W,
        parameter  int X_DIGIT_W = mul_pkg::DEF_X_DIGIT_W,
        parameter  int Y_DIGIT_W = mul_pkg::DEF_Y_DIGIT_W,
        localparam int TERMS     = mul_pkg::term_count(OPERAND_W, X_DIGIT_W, Y_DIGIT_W),
        localparam int PROD_W    = 2 * OPERAND_W
) (
        input  logic                    clk,
        input  logic                    rst_n,

        // operand pair, taken whenever in_valid is high
        input  logic                    in_valid,
        input  logic [OPERAND_W-1:0]    x,
        input  logic [OPERAND_W-1:0]    y,

        // aligned partial products, one cycle later
        output logic                    term_valid,
        output logic [TERMS*PROD_W-1:0] terms
);

        import mul_pkg::*;

        // digit counts per operand
        localparam int X_DIGITS = digit_count(OPERAND_W, X_DIGIT_W);
        localparam int Y_DIGITS = digit_count(OPERAND_W, Y_DIGIT_W);

        // operands padded up to a whole number of digits
        localparam int X_PAD_W  = X_DIGITS * X_DIGIT_W;
        localparam int Y_PAD_W  = Y_DIGITS * Y_DIGIT_W;

        // raw width of one digit product
        localparam int DPROD_W  = X_DIGIT_W + Y_DIGIT_W;

        logic [X_PAD_W-1:0] x_pad;
        logic [Y_PAD_W-1:0] y_pad;

        // shifted digit products before the register
        logic [PROD_W-1:0]  shifted [TERMS];

        // zero-extend, top digits get clean upper bits
        assign x_pad = X_PAD_W'(x);
        assign y_pad = Y_PAD_W'(y);

        // x digit i sits at i*X_DIGIT_W, y digit j at j*Y_DIGIT_W
        // so product (i,j) lands at the sum of the two offsets
        for (genvar i = 0; i < X_DIGITS; i++) begin : g_x_digit
                for (genvar j = 0; j < Y_DIGITS; j++) begin : g_y_digit
                        localparam int IDX   = i * Y_DIGITS + j;
                        localparam int SHIFT = i * X_DIGIT_W + j * Y_DIGIT_W;

                        logic [X_DIGIT_W-1:0] x_digit;
                        logic [Y_DIGIT_W-1:0] y_digit;
                        logic [DPROD_W-1:0]   digit_prod;

                        assign x_digit    = x_pad[i*X_DIGIT_W +: X_DIGIT_W];
                        assign y_digit    = y_pad[j*Y_DIGIT_W +: Y_DIGIT_W];

                        // full 24x16 product, no truncation
                        assign digit_prod = x_digit * y_digit;

                        // padded digits are zero, so the shifted term
                        // never spills past the product width
                        assign shifted[IDX] = PROD_W'(digit_prod) << SHIFT;
                end
        end

        // product register, whole array in one stage
        // data moves every cycle, the tag marks real pairs
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        terms <= '0;
                end else begin
                        for (int t = 0; t < TERMS; t++) begin
                                terms[t*PROD_W +: PROD_W] <= shifted[t];
                        end
                end
        end

        // valid tag, same stage as the products
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        term_valid <= 1'b0;
                end else begin
                        term_valid <= in_valid;
                end
        end

endmodule

/* verilog/adder_tree.sv */
// registered pairwise adder tree for the wide multiplier
// every level adds neighbouring terms of the level below and registers
// the result, an odd last term is carried up unchanged
// the valid tag shifts up one level per cycle beside the data
module adder_tree #(
        parameter  int OPERAND_W = mul_pkg::DEF_OPERAND_W,
        parameter  int X_DIGIT_W = mul_pkg::DEF_X_DIGIT_W,
        parameter  int Y_DIGIT_W = mul_pkg::DEF_Y_DIGIT_W,
        localparam int TERMS     = mul_pkg::term_count(OPERAND_W, X_DIGIT_W, Y_DIGIT_W),
        localparam int PROD_W    = 2 * OPERAND_W
) (
        input  logic                    clk,
        input  logic                    rst_n,

        // aligned partial products from the product array
        input  logic                    term_valid,
        input  logic [TERMS*PROD_W-1:0] terms,

        // full product, tree depth cycles after term_valid
        output logic                    sum_valid,
        output logic [PROD_W-1:0]       sum
);

        import mul_pkg::*;

        // number of register levels
        localparam int DEPTH = tree_depth(TERMS);

        // terms left at a given level, level 0 is the input
        // 176 -> 88 -> 44 -> 22 -> 11 -> 6 -> 3 -> 2 -> 1 at the defaults
        function automatic int level_terms(input int level);
                int n;
                n = TERMS;
                for (int i = 0; i < level; i++) begin
                        n = (n + 1) / 2;
                end
                return n;
        endfunction

        // one generate block per level, one node block per term
        for (genvar l = 0; l <= DEPTH; l++) begin : g_level
                localparam int N = level_terms(l);

                logic valid_q;

                for (genvar k = 0; k < N; k++) begin : g_node
                        logic [PROD_W-1:0] node_q;

                        if (l == 0) begin : g_leaf
                                // input terms, already registered upstream
                                assign node_q = terms[k*PROD_W +: PROD_W];
                        end else if (2 * k + 1 < level_terms(l - 1)) begin : g_pair
                                // sum of two neighbours
                                // mod 2^PROD_W, exact since the product fits
                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n) begin
                                                node_q <= '0;
                                        end else begin
                                                node_q <= g_level[l-1].g_node[2*k].node_q +
                                                          g_level[l-1].g_node[2*k+1].node_q;
                                        end
                                end
                        end else begin : g_pass
                                // odd term out, just delayed one level
                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n) begin
                                                node_q <= '0;
                                        end else begin
                                                node_q <= g_level[l-1].g_node[2*k].node_q;
                                        end
                                end
                        end
                end

                // valid tag keeps pace with the data of this level
                if (l == 0) begin : g_valid_in
                        assign valid_q = term_valid;
                end else begin : g_valid_reg
                        always_ff @(posedge clk or negedge rst_n) begin
                                if (!rst_n) begin
                                        valid_q <= 1'b0;
                                end else begin
                                        valid_q <= g_level[l-1].valid_q;
                                end
                        end
                end
        end

        // top of the tree holds a single term
        assign sum       = g_level[DEPTH].g_node[0].node_q;
        assign sum_valid = g_level[DEPTH].valid_q;

endmodule

/* verilog/wide_multiplier.sv */
// pipelined wide unsigned multiplier, as used in a Montgomery datapath
// accepts one operand pair per clock with no stall and no back-pressure
// product appears mul_latency cycles after the sampling edge, in order
// widths are set here and handed down to both pipeline stages
module wide_multiplier #(
        parameter  int OPERAND_W = mul_pkg::DEF_OPERAND_W,
        parameter  int X_DIGIT_W = mul_pkg::DEF_X_DIGIT_W,
        parameter  int Y_DIGIT_W = mul_pkg::DEF_Y_DIGIT_W,
        localparam int TERMS     = mul_pkg::term_count(OPERAND_W, X_DIGIT_W, Y_DIGIT_W),
        localparam int PROD_W    = 2 * OPERAND_W
) (
        input  logic                 clk,
        input  logic                 rst_n,

        // operand pair and its qualifier
        input  logic                 in_valid,
        input  logic [OPERAND_W-1:0] x,
        input  logic [OPERAND_W-1:0] y,

        // result, must be taken in the cycle out_valid is high
        output logic                 out_valid,
        output logic [PROD_W-1:0]    product
);

        // aligned digit products between the two stages
        logic                    term_valid;
        logic [TERMS*PROD_W-1:0] terms;

        // stage 1, every digit product in one register
        partial_product_array #(
                .OPERAND_W (OPERAND_W),
                .X_DIGIT_W (X_DIGIT_W),
                .Y_DIGIT_W (Y_DIGIT_W)
        ) partial_product_array_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .in_valid   (in_valid),
                .x          (x),
                .y          (y),
                .term_valid (term_valid),
                .terms      (terms)
        );

        // stages 2 onward, one register per tree level
        adder_tree #(
                .OPERAND_W (OPERAND_W),
                .X_DIGIT_W (X_DIGIT_W),
                .Y_DIGIT_W (Y_DIGIT_W)
        ) adder_tree_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .term_valid (term_valid),
                .terms      (terms),
                .sum_valid  (out_valid),
                .sum        (product)
        );

endmodule

/* testbench/wide_multiplier_tb.sv */
// testbench for the pipelined wide multiplier at default widths
// drives operand pairs on the falling edge, keeps a queue of expected
// products and lets concurrent assertions check timing and data
// prints one line per test and then a summary line with the verdict
module wide_multiplier_tb;

        timeunit 1ns;
        timeprecision 1ps;

        import mul_pkg::*;

        localparam int OPERAND_W    = DEF_OPERAND_W;
        localparam int PROD_W       = 2 * OPERAND_W;
        localparam int LAT          = mul_latency(DEF_OPERAND_W, DEF_X_DIGIT_W, DEF_Y_DIGIT_W);
        localparam int X_DIGITS     = digit_count(DEF_OPERAND_W, DEF_X_DIGIT_W);
        localparam int Y_DIGITS     = digit_count(DEF_OPERAND_W, DEF_Y_DIGIT_W);
        localparam int CLK_PERIOD   = 20;

        // stimulus sizes
        localparam int RESET_CYCLES = 4;
        localparam int CORNER_PAIRS = 5 + X_DIGITS + Y_DIGITS;
        localparam int STREAM_N     = 64;
        localparam int GAP_CYCLES   = 128;

        // cycles spent by all tests including drain time
        localparam int STIM_CYCLES  = RESET_CYCLES + (LAT + 2) +
                                      (CORNER_PAIRS + 1) * (LAT + 2) +
                                      (STREAM_N + LAT + 2) +
                                      (GAP_CYCLES + LAT + 2) +
                                      (3 * LAT + 3);
        localparam int WATCHDOG_NS  = (STIM_CYCLES + LAT + 20) * CLK_PERIOD * 2;

        logic                 clk;
        logic                 rst_n;
        logic                 in_valid;
        logic [OPERAND_W-1:0] x;
        logic [OPERAND_W-1:0] y;
        logic                 out_valid;
        logic [PROD_W-1:0]    product;

        int seed;
        int fail_count;
        int tests_passed;
        int tests_failed;
        int errors_at_start;

        // expected products in input order
        logic [PROD_W-1:0] expected_q [$];

        // queue head and size as seen by the concurrent assertions
        logic [PROD_W-1:0] exp_head;
        int                exp_count;

        wide_multiplier wide_multiplier_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .x         (x),
                .y         (y),
                .out_valid (out_valid),
                .product   (product)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // scoreboard of expected products
        // pops on a result and pushes x*y at full width on a sampled input
        always @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        expected_q.delete();
                        exp_head  <= '0;
                        exp_count <= 0;
                end else begin
                        if (out_valid && expected_q.size() != 0) begin
                                void'(expected_q.pop_front());
                        end
                        if (in_valid) begin
                                expected_q.push_back(PROD_W'(x) * PROD_W'(y));
                        end
                        exp_head  <= (expected_q.size() != 0) ? expected_q[0] : '0;
                        exp_count <= expected_q.size();
                end
        end

        // out_valid follows in_valid by exactly LAT edges in both directions
        a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
                        out_valid == $past(in_valid, LAT))
                else begin
                        $display("[FAIL] out_valid expected %h got %h",
                                 !$sampled(out_valid), $sampled(out_valid));
                        fail_count++;
                end

        // each result matches the oldest outstanding input
        a_product_match: assert property (@(posedge clk) disable iff (!rst_n)
                        out_valid |-> (exp_count != 0 && product == exp_head))
                else begin
                        if ($sampled(exp_count) == 0) begin
                                $display("result at %0t ns with no input outstanding", $time);
                        end else begin
                                $display("[FAIL] product expected %h got %h",
                                         $sampled(exp_head), $sampled(product));
                        end
                        fail_count++;
                end

        // nothing leaves the pipe while reset is held
        a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
                else begin
                        $display("out_valid went high while reset was asserted");
                        fail_count++;
                end

        // 8 calls of 32 bits make one 256-bit operand
        function automatic logic [OPERAND_W-1:0] rand_operand();
                logic [OPERAND_W-1:0] r;
                r = '0;
                for (int k = 0; k < OPERAND_W / 32; k++) begin
                        r[k*32 +: 32] = $random(seed);
                end
                return r;
        endfunction

        // coin flip for the gap test
        function automatic logic rand_bit();
                return ($random(seed) & 32'sd1) != 0;
        endfunction

        // one valid pair on the next falling edge
        task automatic send_pair(input logic [OPERAND_W-1:0] a,
                                 input logic [OPERAND_W-1:0] b);
                @(negedge clk);
                in_valid = 1'b1;
                x        = a;
                y        = b;
        endtask

        // idle slot carrying junk that must never show up
        task automatic send_noise();
                @(negedge clk);
                in_valid = 1'b0;
                x        = rand_operand();
                y        = rand_operand();
        endtask

        // stop driving and wait for every result to come out
        task automatic drain();
                @(negedge clk);
                in_valid = 1'b0;
                while (expected_q.size() != 0) begin
                        @(negedge clk);
                end
        endtask

        task automatic single_pair(input logic [OPERAND_W-1:0] a,
                                   input logic [OPERAND_W-1:0] b);
                send_pair(a, b);
                drain();
        endtask

        task automatic begin_test();
                errors_at_start = fail_count;
        endtask

        task automatic end_test(input string name);
                if (fail_count == errors_at_start) begin
                        $display("test %s: ok", name);
                        tests_passed++;
                end else begin
                        $display("test %s: %0d errors", name, fail_count - errors_at_start);
                        tests_failed++;
                end
        endtask

        // watchdog bounded by the length of all tests
        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns, results still outstanding",
                         WATCHDOG_NS);
                $display("Test failed");
                $finish;
        end

        initial begin
                clk             = 1'b0;
                rst_n           = 1'b0;
                in_valid        = 1'b0;
                x               = '0;
                y               = '0;
                seed            = 32'hfe96fae8;
                fail_count      = 0;
                tests_passed    = 0;
                tests_failed    = 0;
                errors_at_start = 0;

                // reset state leaves a quiet output and a cleared product
                begin_test();
                repeat (RESET_CYCLES) @(negedge clk);
                rst_n = 1'b1;
                a_product_zero: assert (product == '0 && out_valid == 1'b0)
                        else begin
                                $display("[FAIL] product expected %h got %h",
                                         {PROD_W{1'b0}}, product);
                                fail_count++;
                        end
                // out_valid must stay low while the pipe is empty
                repeat (LAT + 2) @(negedge clk);
                end_test("reset");

                // zero, one and single bits at every digit boundary
                begin_test();
                single_pair('0, rand_operand());
                single_pair(rand_operand(), '0);
                single_pair(OPERAND_W'(1), rand_operand());
                single_pair(rand_operand(), OPERAND_W'(1));
                for (int i = 0; i < X_DIGITS; i++) begin
                        single_pair(OPERAND_W'(1) << (i * DEF_X_DIGIT_W), rand_operand());
                end
                for (int j = 0; j < Y_DIGITS; j++) begin
                        single_pair(rand_operand(), OPERAND_W'(1) << (j * DEF_Y_DIGIT_W));
                end
                // top bit of both operands
                single_pair(OPERAND_W'(1) << (OPERAND_W - 1), OPERAND_W'(1) << (OPERAND_W - 1));
                end_test("corner");

                // all ones squared gives 2^512 - 2^257 + 1
                // carries ripple through every tree level
                begin_test();
                single_pair('1, '1);
                end_test("carry");

                // one pair per clock gives results on consecutive cycles
                begin_test();
                for (int n = 0; n < STREAM_N; n++) begin
                        send_pair(rand_operand(), rand_operand());
                end
                drain();
                end_test("stream");

                // valid about half the time with junk data in the holes
                begin_test();
                for (int n = 0; n < GAP_CYCLES; n++) begin
                        if (rand_bit()) begin
                                send_pair(rand_operand(), rand_operand());
                        end else begin
                                send_noise();
                        end
                end
                drain();
                end_test("gaps");

                // reset with pairs in flight must drop every one of them
                begin_test();
                for (int n = 0; n < LAT - 1; n++) begin
                        send_pair(rand_operand(), rand_operand());
                end
                @(negedge clk);
                in_valid = 1'b0;
                rst_n    = 1'b0;
                // held past the pipe depth so a tag that escaped reset would surface
                repeat (LAT + 1) @(negedge clk);
                rst_n = 1'b1;
                repeat (LAT + 2) @(negedge clk);
                end_test("reset in flight");

                $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                         tests_passed, tests_failed, fail_count);
                if (tests_failed == 0 && fail_count == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

/* verilog.f */
verilog/mul_pkg.sv
verilog/partial_product_array.sv
verilog/adder_tree.sv
verilog/wide_multiplier.sv
testbench/wide_multiplier_tb.sv

/* Makefile */
# Verilator build for the wide multiplier and its testbench
# make lint   static checks over the whole file list
# make sim    build and run, fails unless the pass message is printed
# make clean  remove build output

TOP = wide_multiplier_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Test completed successfully"

clean:
	rm -rf obj_dir
